/* Makefile */
VERILATOR ?= verilator
TOP       ?= vram_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* source/cell_layout.sv */
`timescale 1ns/100ps
`include "vram_config.svh"

module cell_layout (
  input  vram_pkg::vram_addr_t i_addr,
  input  vram_pkg::time_t      i_time,
  output vram_pkg::glyph_t     o_glyph,
  output vram_pkg::color_t     o_color
);
  import vram_pkg::*;

  localparam color_t clr_red    = '{r: 4'hA, g: 4'h0, b: 4'h0};
  localparam color_t clr_white  = '{r: 4'hF, g: 4'hF, b: 4'hF};
  localparam color_t clr_window = '{r: 4'hF, g: 4'hF, b: 4'h5};
  // first column of the time readout
  localparam int time_col = `VRAM_COLS - 8;

  vram_addr_t row;
  vram_addr_t col;
  glyph_id_e  id;

  // bcd digits above 9 have no glyph
  function automatic glyph_id_e digit_id(logic [3:0] d);
    if (d > 4'd9) begin
      return gid_unknown;
    end
    return glyph_id_e'(d);
  endfunction

  assign row = i_addr / vram_addr_t'(`VRAM_COLS);
  assign col = i_addr % vram_addr_t'(`VRAM_COLS);

  always_comb begin
    id      = gid_window;
    o_color = clr_window;
    if (row == 0) begin
      if (col == 0 || col == `VRAM_COLS - 1) begin
        id      = gid_blank;
        o_color = clr_red;
      end else if (col <= 10) begin
        // digit strip 0..9
        id      = glyph_id_e'(4'(col - 1));
        o_color = clr_white;
      end
    end else if (row == `VRAM_ROWS - 1) begin
      if (col == 0) begin
        id      = gid_blank;
        o_color = clr_red;
      end else if (col >= time_col) begin
        o_color = clr_white;
        case (col)
          time_col + 0: id = digit_id(i_time.h_tens);
          time_col + 1: id = digit_id(i_time.h_units);
          time_col + 3: id = digit_id(i_time.m_tens);
          time_col + 4: id = digit_id(i_time.m_units);
          time_col + 6: id = digit_id(i_time.s_tens);
          time_col + 7: id = digit_id(i_time.s_units);
          default:      id = gid_colon;
        endcase
      end
    end
  end

  assign o_glyph = glyph_bits(id);

endmodule

/* source/frame_writer.sv */
`timescale 1ns/100ps
`include "vram_config.svh"

module frame_writer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 i_end_disp,
  input  vram_pkg::time_t      i_time,
  output vram_pkg::vram_addr_t o_wr_addr,
  output logic                 o_wr_en,
  output vram_pkg::glyph_t     o_wr_glyph,
  output vram_pkg::color_t     o_wr_color,
  output logic                 o_wr_busy
);
  import vram_pkg::*;

  logic       end_disp_q;
  logic       end_rise;
  logic       busy;
  vram_addr_t wr_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      end_disp_q <= 1'b0;
    end else begin
      end_disp_q <= i_end_disp;
    end
  end

  assign end_rise = i_end_disp & ~end_disp_q;

  // a sweep starts out of reset, then again after every frame end
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy   <= 1'b1;
      wr_cnt <= '0;
    end else if (end_rise) begin
      busy   <= 1'b1;
      wr_cnt <= '0;
    end else if (busy) begin
      if (wr_cnt == vram_addr_t'(`VRAM_DEPTH - 1)) begin
        // last cell written, address parks here
        busy <= 1'b0;
      end else begin
        wr_cnt <= wr_cnt + 1'b1;
      end
    end
  end

  cell_layout layout_i (
    .i_addr  (wr_cnt),
    .i_time  (i_time),
    .o_glyph (o_wr_glyph),
    .o_color (o_wr_color)
  );

  assign o_wr_addr = wr_cnt;
  assign o_wr_en   = busy;
  assign o_wr_busy = busy;

endmodule

/* source/pixel_shifter.sv */
`timescale 1ns/100ps

module pixel_shifter (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_vga_clk_en,
  input  logic              i_rgb_on,
  input  logic              i_load,
  input  logic [2:0]        i_row,
  input  vram_pkg::glyph_t  i_glyph,
  input  vram_pkg::color_t  i_color,
  output vram_pkg::pixel_t  o_pixel
);
  import vram_pkg::*;

  pix_line_t row_line;
  pixel_t    pix_q;

  // row 0 sits in the top byte of the glyph
  assign row_line = i_glyph[{3'd7 - i_row, 3'b000} +: 8];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pix_q <= '0;
    end else if (i_vga_clk_en) begin
      if (i_load) begin
        pix_q.line  <= row_line;
        pix_q.color <= i_color;
      end else if (i_rgb_on) begin
        // msb is the pixel on screen, rotate brings the next one up
        pix_q.line <= {pix_q.line[6:0], pix_q.line[7]};
      end
    end
  end

  assign o_pixel = pix_q;

endmodule

/* source/scan_fetch.sv */
`timescale 1ns/100ps
`include "vram_config.svh"

module scan_fetch (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       i_vga_clk_en,
  input  logic                       i_end_disp,
  input  logic [`VRAM_H_CNT_W-1:0]   i_h_cnt,
  input  logic [`VRAM_V_CNT_W-1:0]   i_v_cnt,
  output vram_pkg::vram_addr_t       o_rd_addr,
  output logic                       o_load
);
  import vram_pkg::*;

  logic [`VRAM_H_CNT_W-4:0] cell_col;
  logic [`VRAM_V_CNT_W-4:0] cell_row;
  logic                     on_screen;
  vram_addr_t               cell_addr;
  vram_addr_t               rd_addr;
  vram_addr_t               prev_addr;
  logic                     load;

  // drop the pixel-in-cell bits
  assign cell_col  = i_h_cnt[`VRAM_H_CNT_W-1:3];
  assign cell_row  = i_v_cnt[`VRAM_V_CNT_W-1:3];
  assign on_screen = (cell_col < `VRAM_COLS) && (cell_row < `VRAM_ROWS);
  assign cell_addr = vram_addr_t'(cell_row) * vram_addr_t'(`VRAM_COLS)
                   + vram_addr_t'(cell_col);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr   <= '0;
      prev_addr <= '0;
      load      <= 1'b0;
    end else if (i_vga_clk_en) begin
      prev_addr <= rd_addr;
      // flag for the address taken on the previous enable
      load      <= (rd_addr != prev_addr);
      if (i_end_disp) begin
        rd_addr <= '0;
      end else if (on_screen) begin
        rd_addr <= cell_addr;
      end
    end
  end

  assign o_rd_addr = rd_addr;
  assign o_load    = load;

endmodule

/* source/vram_config.svh */
`ifndef VRAM_CONFIG_SVH
`define VRAM_CONFIG_SVH

// screen in character cells of 8x8 pixels
`define VRAM_COLS 80

`define VRAM_ROWS 60

// one store word per cell
`define VRAM_DEPTH 4800

// enough bits for 4800 cells
`define VRAM_ADDR_W 13

// scan counter widths
// bits [2:0] select the pixel inside a cell,
// the upper bits select the cell column or row
`define VRAM_H_CNT_W 10

`define VRAM_V_CNT_W 10

`endif

/* source/vram_pkg.sv */
`include "vram_config.svh"

package vram_pkg;

  typedef logic [`VRAM_ADDR_W-1:0] vram_addr_t;

  // top pixel row in the msb byte, leftmost pixel in the msb of each byte
  typedef logic [63:0] glyph_t;

  typedef logic [7:0] pix_line_t;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } color_t;

  // bcd time digits
  typedef struct packed {
    logic [3:0] h_tens;
    logic [3:0] h_units;
    logic [3:0] m_tens;
    logic [3:0] m_units;
    logic [3:0] s_tens;
    logic [3:0] s_units;
  } time_t;

  // digits first so a bcd value casts straight to its glyph id
  typedef enum logic [3:0] {
    gid_0,
    gid_1,
    gid_2,
    gid_3,
    gid_4,
    gid_5,
    gid_6,
    gid_7,
    gid_8,
    gid_9,
    gid_colon,
    gid_blank,
    gid_window,
    gid_unknown
  } glyph_id_e;

  typedef struct packed {
    pix_line_t line;
    color_t    color;
  } pixel_t;

  function automatic glyph_t glyph_bits(glyph_id_e id);
    glyph_t bits;
    case (id)
      gid_0:       bits = 64'h3C66_6E76_6666_3C00;
      gid_1:       bits = 64'h1838_1818_1818_7E00;
      gid_2:       bits = 64'h3C66_060C_3060_7E00;
      gid_3:       bits = 64'h3C66_061C_0666_3C00;
      gid_4:       bits = 64'h0C1C_3C6C_7E0C_0C00;
      gid_5:       bits = 64'h7E60_7C06_0666_3C00;
      gid_6:       bits = 64'h3C66_607C_6666_3C00;
      gid_7:       bits = 64'h7E66_0C18_1818_1800;
      gid_8:       bits = 64'h3C66_663C_6666_3C00;
      gid_9:       bits = 64'h3C66_663E_0666_3C00;
      gid_colon:   bits = 64'h0018_1800_1818_0000;
      gid_blank:   bits = 64'h0000_0000_0000_0000;
      // hollow frame
      gid_window:  bits = 64'hFF81_8181_8181_81FF;
      // question mark
      default:     bits = 64'h3C66_060C_1800_1800;
    endcase
    return bits;
  endfunction

endpackage

/* source/vram_store.sv */
`timescale 1ns/100ps
`include "vram_config.svh"

module vram_store #(
  parameter type T = logic [7:0]
) (
  input  logic                 clk,
  input  logic                 i_wr_en,
  input  vram_pkg::vram_addr_t i_wr_addr,
  input  T                     i_wr_data,
  input  vram_pkg::vram_addr_t i_rd_addr,
  output T                     o_rd_data
);

  // one word per screen cell
  T mem [`VRAM_DEPTH];

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // read data follows the address by one clock
  always_ff @(posedge clk) begin
    o_rd_data <= mem[i_rd_addr];
  end

endmodule

/* source/vram_top.sv */
`timescale 1ns/100ps
`include "vram_config.svh"

module vram_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     i_vga_clk_en,
  input  logic                     i_rgb_on,
  input  logic                     i_end_disp,
  input  logic [`VRAM_H_CNT_W-1:0] i_h_cnt,
  input  logic [`VRAM_V_CNT_W-1:0] i_v_cnt,
  input  vram_pkg::time_t          i_time,
  output vram_pkg::pixel_t         o_pixel,
  output logic                     o_wr_busy
);
  import vram_pkg::*;

  // write side
  vram_addr_t wr_addr;
  logic       wr_en;
  glyph_t     wr_glyph;
  color_t     wr_color;

  // read side
  vram_addr_t rd_addr;
  logic       load;
  glyph_t     rd_glyph;
  color_t     rd_color;

  frame_writer writer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_end_disp (i_end_disp),
    .i_time     (i_time),
    .o_wr_addr  (wr_addr),
    .o_wr_en    (wr_en),
    .o_wr_glyph (wr_glyph),
    .o_wr_color (wr_color),
    .o_wr_busy  (o_wr_busy)
  );

  vram_store #(.T(glyph_t)) glyph_store_i (
    .clk       (clk),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_glyph),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_glyph)
  );

  vram_store #(.T(color_t)) color_store_i (
    .clk       (clk),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_color),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_color)
  );

  scan_fetch fetch_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_vga_clk_en (i_vga_clk_en),
    .i_end_disp   (i_end_disp),
    .i_h_cnt      (i_h_cnt),
    .i_v_cnt      (i_v_cnt),
    .o_rd_addr    (rd_addr),
    .o_load       (load)
  );

  pixel_shifter shifter_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_vga_clk_en (i_vga_clk_en),
    .i_rgb_on     (i_rgb_on),
    .i_load       (load),
    .i_row        (i_v_cnt[2:0]),
    .i_glyph      (rd_glyph),
    .i_color      (rd_color),
    .o_pixel      (o_pixel)
  );

endmodule

/* tests/vram_chk.sv */
`timescale 1ns/100ps
`include "vram_config.svh"

module vram_chk (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 i_end_disp,
  input logic                 end_disp_q,
  input vram_pkg::vram_addr_t o_wr_addr,
  input logic                 o_wr_en,
  input logic                 o_wr_busy
);
  import vram_pkg::*;

  logic end_rise;
  // set by any failed assertion below
  logic failed = 1'b0;

  assign end_rise = i_end_disp & ~end_disp_q;

  addr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    o_wr_en |-> o_wr_addr < vram_addr_t'(`VRAM_DEPTH))
    else begin
      failed = 1'b1;
      $error("write address beyond the store");
    end

  // a new sweep only follows a frame end edge
  busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(o_wr_busy) |-> $past(end_rise))
    else begin
      failed = 1'b1;
      $error("busy rose without a frame end edge");
    end

  addr_step: assert property (@(posedge clk) disable iff (!rst_n)
    (o_wr_busy && !end_rise && o_wr_addr != vram_addr_t'(`VRAM_DEPTH - 1))
    |=> (o_wr_addr == $past(o_wr_addr) + 1'b1))
    else begin
      failed = 1'b1;
      $error("write address did not step by one");
    end

endmodule

bind frame_writer vram_chk chk_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .i_end_disp (i_end_disp),
  .end_disp_q (end_disp_q),
  .o_wr_addr  (o_wr_addr),
  .o_wr_en    (o_wr_en),
  .o_wr_busy  (o_wr_busy)
);

/* tests/vram_tb.sv */
`timescale 1ns/100ps
`include "vram_config.svh"

module vram_tb;
  import vram_pkg::*;

  localparam real clk_period = 8.0;
  // reset sweep, restart sweep, time update sweep
  localparam int n_sweeps = 3;
  localparam int enables_per_sweep = 200;
  localparam real timeout_ns =
    n_sweeps * (`VRAM_DEPTH + enables_per_sweep * 5) * clk_period + 2000.0;
  localparam int n_probes = 24;
  localparam int time_col = `VRAM_COLS - 8;

  logic                     clk;
  logic                     rst_n;
  logic                     i_vga_clk_en;
  logic                     i_rgb_on;
  logic                     i_end_disp;
  logic [`VRAM_H_CNT_W-1:0] i_h_cnt;
  logic [`VRAM_V_CNT_W-1:0] i_v_cnt;
  time_t                    i_time;
  pixel_t                   o_pixel;
  logic                     o_wr_busy;

  logic [15:0] lfsr_state;
  // read address the DUT holds right now
  int          last_addr;

  vram_top vram_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_vga_clk_en (i_vga_clk_en),
    .i_rgb_on     (i_rgb_on),
    .i_end_disp   (i_end_disp),
    .i_h_cnt      (i_h_cnt),
    .i_v_cnt      (i_v_cnt),
    .i_time       (i_time),
    .o_pixel      (o_pixel),
    .o_wr_busy    (o_wr_busy)
  );

  initial clk = 1'b0;
  always #(clk_period / 2.0) clk = ~clk;

  // x^16 + x^14 + x^13 + x^11
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      r = (r << 1) | int'(lfsr_bit());
    end
    return r;
  endfunction

  function automatic pix_line_t rotl(pix_line_t x, int n);
    pix_line_t y;
    y = x;
    for (int i = 0; i < n; i++) begin
      y = {y[6:0], y[7]};
    end
    return y;
  endfunction

  function automatic glyph_t digit_glyph(logic [3:0] d);
    if (d > 4'd9) begin
      return glyph_bits(gid_unknown);
    end
    return glyph_bits(glyph_id_e'(d));
  endfunction

  // reference screen content
  task automatic cell_model(input int row, input int col, input time_t tm,
                            output glyph_t g, output color_t c);
    g = glyph_bits(gid_window);
    c = '{r: 4'hF, g: 4'hF, b: 4'h5};
    if (row == 0 && (col == 0 || col == 79)) begin
      g = glyph_bits(gid_blank);
      c = '{r: 4'hA, g: 4'h0, b: 4'h0};
    end else if (row == 0 && col <= 10) begin
      g = glyph_bits(glyph_id_e'(col - 1));
      c = '{r: 4'hF, g: 4'hF, b: 4'hF};
    end else if (row == 59 && col == 0) begin
      g = glyph_bits(gid_blank);
      c = '{r: 4'hA, g: 4'h0, b: 4'h0};
    end else if (row == 59 && col >= time_col) begin
      c = '{r: 4'hF, g: 4'hF, b: 4'hF};
      case (col - time_col)
        0: g = digit_glyph(tm.h_tens);
        1: g = digit_glyph(tm.h_units);
        3: g = digit_glyph(tm.m_tens);
        4: g = digit_glyph(tm.m_units);
        6: g = digit_glyph(tm.s_tens);
        7: g = digit_glyph(tm.s_units);
        default: g = glyph_bits(gid_colon);
      endcase
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_line(input string name, input pix_line_t got, input pix_line_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      fail_run("pixel line mismatch");
    end
  endtask

  task automatic check_color(input string name, input color_t got, input color_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      fail_run("colour mismatch");
    end
  endtask

  task automatic check_busy(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      fail_run("writer busy mismatch");
    end
  endtask

  // one enable, then 1 to 4 idle clocks
  task automatic pulse_enable();
    int idle;
    i_vga_clk_en = 1'b1;
    @(negedge clk);
    i_vga_clk_en = 1'b0;
    idle = 1 + rand_bits(2);
    repeat (idle) @(negedge clk);
  endtask

  task automatic end_disp_pulse();
    i_end_disp = 1'b1;
    @(negedge clk);
    i_end_disp = 1'b0;
  endtask

  // busy must stay high for exactly one sweep from this edge
  task automatic check_sweep();
    for (int i = 0; i < `VRAM_DEPTH; i++) begin
      check_busy("o_wr_busy", o_wr_busy, 1'b1);
      @(negedge clk);
    end
    check_busy("o_wr_busy", o_wr_busy, 1'b0);
  endtask

  task automatic wait_sweep_done();
    while (o_wr_busy) begin
      @(negedge clk);
    end
  endtask

  task automatic probe_cell(input int row, input int col, input logic [2:0] vrow,
                            input bit rotate);
    glyph_t    g;
    color_t    c;
    pix_line_t line;
    if (row * `VRAM_COLS + col == last_addr) begin
      col = (col + 1) % `VRAM_COLS;
    end
    cell_model(row, col, i_time, g, c);
    line = g[63 - 8 * vrow -: 8];
    i_rgb_on = 1'b0;
    i_h_cnt = `VRAM_H_CNT_W'(col * 8 + rand_bits(3));
    i_v_cnt = `VRAM_V_CNT_W'(row * 8 + vrow);
    last_addr = row * `VRAM_COLS + col;
    repeat (3) pulse_enable();
    check_line("o_pixel.line", o_pixel.line, line);
    check_color("o_pixel.color", o_pixel.color, c);
    if (rotate) begin
      i_rgb_on = 1'b1;
      for (int i = 1; i <= 8; i++) begin
        pulse_enable();
        check_line("o_pixel.line", o_pixel.line, rotl(line, i));
      end
      i_rgb_on = 1'b0;
      repeat (2) begin
        pulse_enable();
        check_line("o_pixel.line", o_pixel.line, line);
        check_color("o_pixel.color", o_pixel.color, c);
      end
    end
  endtask

  initial begin
    #(timeout_ns);
    fail_run("run timed out before all tests finished");
  end

  // writer assertions raise a flag in the bound checker
  always @(negedge clk) begin
    if (vram_top_i.writer_i.chk_i.failed) begin
      fail_run("an assertion in the frame writer checker failed");
    end
  end

  initial begin
    pixel_t held;
    int     row;
    int     sel;
    lfsr_state   = 16'd10;
    last_addr    = 0;
    rst_n        = 1'b0;
    i_vga_clk_en = 1'b0;
    i_rgb_on     = 1'b0;
    i_end_disp   = 1'b0;
    i_h_cnt      = '0;
    i_v_cnt      = '0;
    i_time       = time_t'(rand_bits(24));
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // pixel output starts cleared
    check_line("o_pixel.line", o_pixel.line, 8'h00);
    check_color("o_pixel.color", o_pixel.color, '{r: 4'h0, g: 4'h0, b: 4'h0});

    // sweep after reset, then a restart
    check_sweep();
    end_disp_pulse();
    check_sweep();

    // random cells, every fourth one also rotated
    for (int p = 0; p < n_probes; p++) begin
      sel = rand_bits(2);
      if (sel == 0) begin
        row = 0;
      end else if (sel == 1) begin
        row = 59;
      end else begin
        row = 1 + rand_bits(6) % 58;
      end
      probe_cell(row, rand_bits(7) % 80, 3'(rand_bits(3)), (p % 4) == 3);
    end

    // off-screen counters keep the pixel
    held = o_pixel;
    for (int i = 0; i < 10; i++) begin
      if (i % 2 == 0) begin
        i_h_cnt = `VRAM_H_CNT_W'((80 + rand_bits(5)) * 8 + rand_bits(3));
        i_v_cnt = `VRAM_V_CNT_W'((rand_bits(5)) * 8 + rand_bits(3));
      end else begin
        i_h_cnt = `VRAM_H_CNT_W'((rand_bits(6)) * 8 + rand_bits(3));
        i_v_cnt = `VRAM_V_CNT_W'((60 + rand_bits(3)) * 8 + rand_bits(3));
      end
      pulse_enable();
      check_line("o_pixel.line", o_pixel.line, held.line);
      check_color("o_pixel.color", o_pixel.color, held.color);
    end

    // new time digits with at least one invalid
    i_time = time_t'(rand_bits(24));
    i_time.h_tens = 4'(10 + rand_bits(2));
    end_disp_pulse();
    wait_sweep_done();
    for (int col = time_col; col < `VRAM_COLS; col++) begin
      probe_cell(59, col, 3'(rand_bits(3)), 1'b0);
    end

    if (vram_top_i.writer_i.chk_i.failed) begin
      fail_run("an assertion in the frame writer checker failed");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

/* vlog.f */
+incdir+source
source/vram_pkg.sv
source/cell_layout.sv
source/frame_writer.sv
source/vram_store.sv
source/scan_fetch.sv
source/pixel_shifter.sv
source/vram_top.sv
tests/vram_chk.sv
tests/vram_tb.sv
